//--- hdl/bchPkg.sv
package bchPkg;

	// BCH(15,5) with t = 3 over GF(16), primitive polynomial x^4 + x + 1
	localparam int codeN = 15;
	localparam int codeK = 5;
	localparam int codeT = 3;
	localparam int fieldM = 4;

	typedef logic [fieldM-1:0] gf_t;
	typedef logic [codeN-1:0] codeword_t; // bit 14 is the highest-degree coefficient

	typedef struct packed {
		gf_t s1;
		gf_t s3;
		gf_t s5;
	} synd_t;

	// an all-zero locator means the solver ran past codeT and the word cannot be decoded
	typedef struct packed {
		gf_t sigma0;
		gf_t sigma1;
		gf_t sigma2;
		gf_t sigma3;
		logic [1:0] degree;
	} locator_t;

	typedef struct packed {
		codeword_t corrected;
		logic [1:0] errCount;
		logic uncorrectable;
	} decodeResult_t;

	localparam logic [3:0] regData = 4'h0;
	localparam logic [3:0] regStatus = 4'h4;
	localparam logic [3:0] regResult = 4'h8;

	// shift-and-add multiply, reducing by x^4 = x + 1 after every shift
	function automatic gf_t gfMul(input gf_t a, input gf_t b);
		gf_t prod;
		gf_t shifted;
		prod = '0;
		shifted = a;
		for (int i = 0; i < fieldM; i++) begin
			if (b[i])
				prod ^= shifted;
			shifted = {shifted[fieldM-2:0], 1'b0} ^ (shifted[fieldM-1] ? 4'b0011 : 4'b0000);
		end
		return prod;
	endfunction

	function automatic gf_t gfSquare(input gf_t a);
		return {a[3], a[1] ^ a[3], a[2], a[0] ^ a[2]}; // squaring is linear in characteristic 2
	endfunction

endpackage

//--- hdl/bchApbRegs.sv
`timescale 1ns/1ns

module bchApbRegs (
	input logic clk,
	input logic reset,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [3:0] paddr,
	input logic [31:0] pwdata,
	input logic finish,
	input bchPkg::decodeResult_t result,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	output logic start,
	output bchPkg::codeword_t received,
	output logic busy
);
	logic access;
	logic mapped;
	logic dataWrite;
	logic refused;
	logic done;
	bchPkg::decodeResult_t latched;

	assign access = psel && penable;
	assign mapped = paddr == bchPkg::regData || paddr == bchPkg::regStatus ||
		paddr == bchPkg::regResult;
	assign dataWrite = access && pwrite && paddr == bchPkg::regData && !busy;

	// only the data register takes writes, and only while the decoder is idle
	assign refused = pwrite ? (paddr != bchPkg::regData || busy) : !mapped;
	assign pready = 1'b1;
	assign pslverr = access && refused;

	always_comb begin
		prdata = '0;
		if (psel && !pwrite) begin
			case (paddr)
				bchPkg::regData: prdata[14:0] = received;
				bchPkg::regStatus: prdata[5:0] = {latched.errCount, 1'b0,
					latched.uncorrectable, done, busy};
				bchPkg::regResult: prdata[14:0] = latched.corrected;
				default: prdata = '0; // unmapped reads return zero
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (dataWrite)
			received <= pwdata[14:0];
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			start <= 1'b0;
			busy <= 1'b0;
			done <= 1'b0;
			latched <= '0;
		end else begin
			start <= dataWrite; // one-cycle pulse
			if (dataWrite) begin
				busy <= 1'b1;
				done <= 1'b0;
			end else if (finish) begin
				busy <= 1'b0;
				done <= 1'b1;
				latched <= result;
			end
		end
	end

	// the control block only finishes a word that was launched and is still in flight
	assert property (@(posedge clk) disable iff (reset) finish |-> busy);

endmodule

//--- hdl/bchDecodeControl.sv
`timescale 1ns/1ns

module bchDecodeControl (
	input logic clk,
	input logic reset,
	input logic start,
	output logic synShift,
	output logic [3:0] bitSel,
	output logic bmStart,
	output logic chienStep,
	output logic finish
);
	localparam logic [2:0] phaseIdle = 3'd0;
	localparam logic [2:0] phaseSyndrome = 3'd1;
	localparam logic [2:0] phaseSolve = 3'd2;
	localparam logic [2:0] phaseSearch = 3'd3;
	localparam logic [2:0] phaseFinish = 3'd4;

	logic [2:0] phase;
	logic [3:0] bitCount;
	logic [1:0] iterCount;
	logic bitLast;
	logic iterLast;

	assign bitLast = bitCount == 4'd0; // bits are walked from 14 down to 0
	assign iterLast = iterCount == 2'(bchPkg::codeT - 1);

	assign synShift = phase == phaseSyndrome;
	assign bmStart = phase == phaseSolve && iterCount == 2'd0; // first of the solver cycles
	assign chienStep = phase == phaseSearch;
	assign finish = phase == phaseFinish;
	assign bitSel = bitCount;

	always_ff @(posedge clk) begin
		if (reset) begin
			phase <= phaseIdle;
			bitCount <= '0;
			iterCount <= '0;
		end else begin
			case (phase)
				phaseIdle:
					if (start) begin
						phase <= phaseSyndrome;
						bitCount <= 4'(bchPkg::codeN - 1);
					end
				phaseSyndrome:
					if (bitLast) begin
						phase <= phaseSolve;
						iterCount <= '0;
					end else
						bitCount <= bitCount - 4'd1;
				phaseSolve:
					if (iterLast) begin
						phase <= phaseSearch;
						bitCount <= 4'(bchPkg::codeN - 1);
					end else
						iterCount <= iterCount + 2'd1;
				phaseSearch:
					if (bitLast)
						phase <= phaseFinish;
					else
						bitCount <= bitCount - 4'd1;
				default:
					phase <= phaseIdle; // finish lasts a single cycle
			endcase
		end
	end

	// a start that arrives in mid decode would be lost
	assert property (@(posedge clk) disable iff (reset) start |-> phase == phaseIdle);

endmodule

//--- hdl/bchSyndrome.sv
`timescale 1ns/1ns

module bchSyndrome (
	input logic clk,
	input logic reset,
	input logic start,
	input logic synShift,
	input logic [3:0] bitSel,
	input bchPkg::codeword_t received,
	output bchPkg::synd_t synd
);
	// evaluation points alpha, alpha^3 and alpha^5 in polynomial basis
	localparam bchPkg::gf_t alpha1 = 4'b0010;
	localparam bchPkg::gf_t alpha3 = 4'b1000;
	localparam bchPkg::gf_t alpha5 = 4'b0110;

	logic rxBit;
	bchPkg::gf_t rxTerm;
	bchPkg::synd_t nextSynd;

	assign rxBit = received[bitSel];
	assign rxTerm = {3'b000, rxBit};

	// one Horner step per bit, highest coefficient first
	always_comb begin
		nextSynd.s1 = bchPkg::gfMul(synd.s1, alpha1) ^ rxTerm;
		nextSynd.s3 = bchPkg::gfMul(synd.s3, alpha3) ^ rxTerm;
		nextSynd.s5 = bchPkg::gfMul(synd.s5, alpha5) ^ rxTerm;
	end

	always_ff @(posedge clk) begin
		if (reset || start)
			synd <= '0;
		else if (synShift)
			synd <= nextSynd;
	end

endmodule

//--- hdl/bchBerlekamp.sv
`timescale 1ns/1ns

module bchBerlekamp (
	input logic clk,
	input logic reset,
	input logic bmStart,
	input bchPkg::synd_t synd,
	output bchPkg::locator_t locator
);
	bchPkg::gf_t s2;
	bchPkg::gf_t s4;
	bchPkg::gf_t window [0:3];
	bchPkg::gf_t sigma [0:3];
	bchPkg::gf_t lambda [0:3];
	bchPkg::gf_t curSigma [0:3];
	bchPkg::gf_t curLambda [0:3];
	bchPkg::gf_t nextSigma [0:3];
	bchPkg::gf_t nextLambda [0:3];
	bchPkg::gf_t gamma;
	bchPkg::gf_t curGamma;
	bchPkg::gf_t delta;
	logic [2:0] len;
	logic [2:0] curLen;
	logic [1:0] iter;
	logic [1:0] curIter;
	logic active;
	logic update;
	logic overflow;

	assign s2 = bchPkg::gfSquare(synd.s1);
	assign s4 = bchPkg::gfSquare(s2);

	// bmStart runs the first iteration straight from the initial polynomials
	assign curIter = bmStart ? 2'd0 : iter;
	assign curGamma = bmStart ? 4'd1 : gamma;
	assign curLen = bmStart ? 3'd0 : len;
	assign active = bmStart || iter != 2'(bchPkg::codeT);

	always_comb begin
		for (int j = 0; j < 4; j++) begin
			curSigma[j] = bmStart ? bchPkg::gf_t'(j == 0) : sigma[j];
			curLambda[j] = bmStart ? bchPkg::gf_t'(j == 0) : lambda[j];
		end
		case (curIter)
			2'd0: window = '{synd.s1, 4'd0, 4'd0, 4'd0};
			2'd1: window = '{synd.s3, s2, synd.s1, 4'd0};
			default: window = '{synd.s5, s4, synd.s3, s2};
		endcase
		delta = '0;
		for (int j = 0; j < 4; j++)
			delta ^= bchPkg::gfMul(curSigma[j], window[j]);
		update = delta != 4'd0 && curLen <= {1'b0, curIter};

		nextSigma[0] = bchPkg::gfMul(curGamma, curSigma[0]);
		for (int j = 1; j < 4; j++)
			nextSigma[j] = bchPkg::gfMul(curGamma, curSigma[j]) ^
				bchPkg::gfMul(delta, curLambda[j-1]);

		nextLambda[0] = '0;
		nextLambda[1] = update ? curSigma[0] : 4'd0;
		for (int j = 2; j < 4; j++)
			nextLambda[j] = update ? curSigma[j-1] : curLambda[j-2]; // x*sigma or x^2*lambda
	end

	always_ff @(posedge clk) begin
		if (reset)
			iter <= 2'(bchPkg::codeT); // idle
		else if (bmStart)
			iter <= 2'd1;
		else if (active)
			iter <= iter + 2'd1;
	end

	always_ff @(posedge clk) begin
		if (active) begin
			sigma <= nextSigma;
			lambda <= nextLambda;
			gamma <= update ? delta : curGamma;
			len <= update ? ({curIter, 1'b1} - curLen) : curLen;
		end
	end

	assign overflow = len > 3'(bchPkg::codeT);

	always_comb begin
		locator = '0;
		if (!overflow) begin
			locator.sigma0 = sigma[0];
			locator.sigma1 = sigma[1];
			locator.sigma2 = sigma[2];
			locator.sigma3 = sigma[3];
			locator.degree = len[1:0];
		end
	end

endmodule

//--- hdl/bchChien.sv
`timescale 1ns/1ns

module bchChien (
	input logic clk,
	input logic reset,
	input logic bmStart,
	input logic chienStep,
	input logic [3:0] bitSel,
	input bchPkg::codeword_t received,
	input bchPkg::locator_t locator,
	output bchPkg::decodeResult_t result
);
	localparam bchPkg::gf_t alpha1 = 4'b0010;
	localparam bchPkg::gf_t alpha2 = 4'b0100;
	localparam bchPkg::gf_t alpha3 = 4'b1000;

	bchPkg::gf_t term1;
	bchPkg::gf_t term2;
	bchPkg::gf_t term3;
	bchPkg::gf_t cur1;
	bchPkg::gf_t cur2;
	bchPkg::gf_t cur3;
	bchPkg::gf_t evalSum;
	bchPkg::codeword_t corrWord;
	logic [3:0] rootCount;
	logic firstStep;
	logic isRoot;
	logic uncorrectable;

	// bit 14 is tested at alpha^1, so the terms start one step in
	assign firstStep = bitSel == 4'(bchPkg::codeN - 1);
	assign cur1 = firstStep ? bchPkg::gfMul(locator.sigma1, alpha1) : term1;
	assign cur2 = firstStep ? bchPkg::gfMul(locator.sigma2, alpha2) : term2;
	assign cur3 = firstStep ? bchPkg::gfMul(locator.sigma3, alpha3) : term3;
	assign evalSum = locator.sigma0 ^ cur1 ^ cur2 ^ cur3;
	assign isRoot = chienStep && evalSum == 4'd0;

	always_ff @(posedge clk) begin
		if (chienStep) begin
			term1 <= bchPkg::gfMul(cur1, alpha1);
			term2 <= bchPkg::gfMul(cur2, alpha2);
			term3 <= bchPkg::gfMul(cur3, alpha3);
		end
		if (bmStart)
			corrWord <= received;
		else if (isRoot)
			corrWord[bitSel] <= !corrWord[bitSel]; // flip the located error
	end

	always_ff @(posedge clk) begin
		if (reset || bmStart)
			rootCount <= '0;
		else if (isRoot)
			rootCount <= rootCount + 4'd1;
	end

	// a locator that does not split into distinct roots over the code is a failure
	assign uncorrectable = rootCount != {2'b00, locator.degree};
	assign result.corrected = uncorrectable ? received : corrWord;
	assign result.errCount = uncorrectable ? 2'd0 : rootCount[1:0];
	assign result.uncorrectable = uncorrectable;

	// a nonzero locator of degree three or less has at most three roots
	assert property (@(posedge clk) disable iff (reset)
		chienStep && bitSel == 4'd0 |=> rootCount <= 4'(bchPkg::codeT) || locator == '0);

endmodule

//--- hdl/bchDecoderTop.sv
`timescale 1ns/1ns

module bchDecoderTop (
	input logic clk,
	input logic reset,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [3:0] paddr,
	input logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr
);
	logic start;
	logic synShift;
	logic [3:0] bitSel;
	logic bmStart;
	logic chienStep;
	logic finish;
	bchPkg::codeword_t received;
	bchPkg::synd_t synd;
	bchPkg::locator_t locator;
	bchPkg::decodeResult_t result;

	bchApbRegs i_regs (.clk(clk), .reset(reset), .psel(psel), .penable(penable),
		.pwrite(pwrite), .paddr(paddr), .pwdata(pwdata), .finish(finish), .result(result),
		.prdata(prdata), .pready(pready), .pslverr(pslverr), .start(start),
		.received(received), .busy());

	bchDecodeControl i_control (.clk(clk), .reset(reset), .start(start),
		.synShift(synShift), .bitSel(bitSel), .bmStart(bmStart), .chienStep(chienStep),
		.finish(finish));

	bchSyndrome i_syndrome (.clk(clk), .reset(reset), .start(start), .synShift(synShift),
		.bitSel(bitSel), .received(received), .synd(synd));

	bchBerlekamp i_berlekamp (.clk(clk), .reset(reset), .bmStart(bmStart), .synd(synd),
		.locator(locator));

	bchChien i_chien (.clk(clk), .reset(reset), .bmStart(bmStart), .chienStep(chienStep),
		.bitSel(bitSel), .received(received), .locator(locator), .result(result));

endmodule

//--- bench/bchDecoderTb.sv
`timescale 1ns/1ns

module bchDecoderTb;
	localparam logic [10:0] generatorPoly = 11'h537; // x^10 + x^8 + x^5 + x^4 + x^2 + x + 1
	localparam int apbTimeout = 8;
	localparam int doneTimeout = 40; // each status poll takes two cycles
	localparam int rowCount = 12;

	logic clk;
	logic reset;
	logic psel;
	logic penable;
	logic pwrite;
	logic [3:0] paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic pready;
	logic pslverr;

	integer seed = 32'ha940d282;
	int errorCount = 0;
	int timeoutCount = 0;

	// a weight of zero applies the fixed mask, otherwise a random mask of that weight is drawn
	string rowName [0:rowCount-1] = '{"noErrorZero", "noErrorMixed", "singleTop",
		"singleBottom", "doubleMid", "tripleSpread", "tripleAdjacent", "tripleHigh",
		"randomFourA", "randomFiveA", "randomFourB", "randomFiveB"};
	logic [4:0] rowMsg [0:rowCount-1] = '{5'h00, 5'h15, 5'h1f, 5'h0a, 5'h13, 5'h07, 5'h1c,
		5'h11, 5'h0d, 5'h16, 5'h19, 5'h02};
	logic [14:0] rowMask [0:rowCount-1] = '{15'h0000, 15'h0000, 15'h4000, 15'h0001,
		15'h0810, 15'h4201, 15'h0070, 15'h7000, 15'h0000, 15'h0000, 15'h0000, 15'h0000};
	int rowWeight [0:rowCount-1] = '{0, 0, 0, 0, 0, 0, 0, 0, 4, 5, 4, 5};

	bchDecoderTop i_dut (.clk(clk), .reset(reset), .psel(psel), .penable(penable),
		.pwrite(pwrite), .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
		.pslverr(pslverr));

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic int countOnes(input logic [14:0] value);
		int ones;
		ones = 0;
		for (int i = 0; i < 15; i++)
			ones += value[i];
		return ones;
	endfunction

	// long division by the generator, bit 14 is the leading coefficient
	function automatic logic [9:0] remainder(input logic [14:0] word);
		logic [14:0] rest;
		rest = word;
		for (int i = 14; i >= 10; i--)
			if (rest[i])
				rest = rest ^ (15'(generatorPoly) << (i - 10));
		return rest[9:0];
	endfunction

	function automatic logic [14:0] encode(input logic [4:0] msg);
		return {msg, remainder({msg, 10'b0})}; // systematic, message in the top bits
	endfunction

	task automatic checkValue(input string name, input string what, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			$display("ERR %s %s expected %h actual %h", name, what, expected, actual);
			errorCount++;
		end
	endtask

	task automatic makeRandomMask(input int weight, output logic [14:0] mask);
		mask = '0;
		while (countOnes(mask) < weight)
			mask[$unsigned($random(seed)) % 15] = 1'b1;
	endtask

	// every transfer starts one ns after a rising edge and ends one ns after one
	task automatic apbTransfer(input logic write, input logic [3:0] addr,
			input logic [31:0] data, output logic [31:0] rdata, output logic err);
		int waitCycles;
		psel = 1'b1;
		penable = 1'b0;
		pwrite = write;
		paddr = addr;
		pwdata = data;
		@(posedge clk);
		#1 penable = 1'b1;
		waitCycles = 0;
		@(negedge clk);
		while (!pready && waitCycles < apbTimeout) begin
			@(negedge clk);
			waitCycles++;
		end
		if (!pready) begin
			$display("APB access to offset %h was never completed by the slave", addr);
			timeoutCount++;
		end
		rdata = prdata;
		err = pslverr;
		@(posedge clk);
		#1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic apbWrite(input logic [3:0] addr, input logic [31:0] data, output logic err);
		logic [31:0] unused;
		apbTransfer(1'b1, addr, data, unused, err);
	endtask

	task automatic apbRead(input logic [3:0] addr, output logic [31:0] data, output logic err);
		apbTransfer(1'b0, addr, '0, data, err);
	endtask

	task automatic waitDone(input string name, output logic [31:0] status);
		logic err;
		int polls;
		polls = 0;
		apbRead(bchPkg::regStatus, status, err);
		while (!status[1] && polls < doneTimeout) begin
			apbRead(bchPkg::regStatus, status, err);
			polls++;
		end
		if (!status[1]) begin
			$display("%s: the decoder never finished within %0d status polls", name, doneTimeout);
			timeoutCount++;
		end
	endtask

	task automatic decodeWord(input string name, input logic [14:0] word,
			output logic [31:0] status, output logic [14:0] corrected);
		logic err;
		logic [31:0] data;
		apbWrite(bchPkg::regData, {17'b0, word}, err);
		checkValue(name, "write pslverr", 0, err);
		apbRead(bchPkg::regStatus, data, err);
		checkValue(name, "busy after start", 1, data[0]);
		waitDone(name, status);
		checkValue(name, "busy after done", 0, status[0]);
		apbRead(bchPkg::regResult, data, err);
		corrected = data[14:0];
	endtask

	initial begin
		logic err;
		logic [31:0] data;
		logic [31:0] status;
		logic [14:0] mask;
		logic [14:0] codeword;
		logic [14:0] rxWord;
		logic [14:0] corrected;
		reset = 1'b1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		repeat (3) @(posedge clk);
		#1 reset = 1'b0;

		apbRead(bchPkg::regStatus, data, err);
		checkValue("resetStatus", "status", 0, data);
		checkValue("resetStatus", "pslverr", 0, err);

		for (int row = 0; row < rowCount; row++) begin
			if (rowWeight[row] == 0)
				mask = rowMask[row];
			else
				makeRandomMask(rowWeight[row], mask);
			codeword = encode(rowMsg[row]);
			rxWord = codeword ^ mask;
			decodeWord(rowName[row], rxWord, status, corrected);
			if (rowWeight[row] == 0) begin
				checkValue(rowName[row], "corrected word", codeword, corrected);
				checkValue(rowName[row], "errCount", countOnes(mask), status[5:4]);
				checkValue(rowName[row], "uncorrectable", 0, status[2]);
			end else if (!status[2]) begin
				// beyond t errors a decode is only legal onto another codeword within t
				checkValue(rowName[row], "syndrome of result", 0, remainder(corrected));
				checkValue(rowName[row], "flipped bits", countOnes(corrected ^ rxWord),
					status[5:4]);
				checkValue(rowName[row], "distance within t", 1,
					countOnes(corrected ^ rxWord) <= bchPkg::codeT);
			end
		end

		// a second word written while busy must be refused and leave the first intact
		codeword = encode(5'h0b);
		apbWrite(bchPkg::regData, {17'b0, codeword ^ 15'h0100}, err);
		checkValue("overlapWrite", "first pslverr", 0, err);
		apbWrite(bchPkg::regData, {17'b0, encode(5'h14)}, err);
		checkValue("overlapWrite", "second pslverr", 1, err);
		waitDone("overlapWrite", status);
		apbRead(bchPkg::regResult, data, err);
		checkValue("overlapWrite", "corrected word", codeword, data[14:0]);
		checkValue("overlapWrite", "errCount", 1, status[5:4]);

		apbWrite(4'hc, 32'h0000_1234, err);
		checkValue("unmappedWrite", "pslverr", 1, err);
		apbWrite(bchPkg::regStatus, 32'h0000_00ff, err);
		checkValue("statusWrite", "pslverr", 1, err);
		apbRead(4'hc, data, err);
		checkValue("unmappedRead", "data", 0, data);
		checkValue("unmappedRead", "pslverr", 1, err);
		apbRead(bchPkg::regResult, data, err);
		checkValue("resultRead", "pslverr", 0, err);

		$display("value mismatches: %0d, timeouts: %0d", errorCount, timeoutCount);
		if (errorCount == 0 && timeoutCount == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

//--- filelist.f
hdl/bchPkg.sv
hdl/bchApbRegs.sv
hdl/bchDecodeControl.sv
hdl/bchSyndrome.sv
hdl/bchBerlekamp.sv
hdl/bchChien.sv
hdl/bchDecoderTop.sv
bench/bchDecoderTb.sv
